/* hdl/sdram_settings.svh */
// SDRAM controller settings: address geometry, bank count and command timing
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// host side byte address, 16 MB
`define SDRAM_AXI_AW 24

// device geometry
`define SDRAM_ROW_W  13
`define SDRAM_COL_W  9   // 16-bit word columns
`define SDRAM_BANKS  4

// timing in clock cycles
`define SDRAM_CL     2
`define SDRAM_TRP    2   // idle cycles after precharge
`define SDRAM_TRCD   2   // idle cycles after activate
`define SDRAM_TRRD   2   // activate to activate, any bank

`endif

/* hdl/sdram_cmd_pkg.sv */
// SDRAM-side types: command codes, bank engine states and the command bus bid
`include "sdram_settings.svh"

package sdram_cmd_pkg;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        NOP       = 4'b0111,
        ACTIVE    = 4'b0011,
        READ      = 4'b0101,
        WRITE     = 4'b0100,
        PRECHARGE = 4'b0010,
        INHIBIT   = 4'b1000
    } cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        PRE_WAIT,
        ACT_WAIT,
        XFER,
        DONE
    } bank_state_e;

    // one bank's bid for the shared command pins
    typedef struct packed {
        logic                            br;
        cmd_e                            cmd;
        logic [$clog2(`SDRAM_BANKS)-1:0] ba;
        logic [`SDRAM_ROW_W-1:0]         a;
        logic                            launch_rd;  // READ goes out if granted
        logic                            launch_wr;
        logic                            act;        // starts a tRRD window
    } bank_pins_t;

endpackage

/* hdl/sdram_host_pkg.sv */
// host-side types: per-bank access requests and completions back to the AXI front end
`include "sdram_settings.svh"

package sdram_host_pkg;

    // one 32-bit access held in a bank slot
    typedef struct packed {
        logic                    valid;
        logic                    we;
        logic [`SDRAM_ROW_W-1:0] row;
        logic [`SDRAM_COL_W-1:0] col;
        logic [31:0]             wdata;
        logic [3:0]              wstrb;
    } bank_req_t;

    // completion, one cycle pulse
    typedef struct packed {
        logic                            valid;
        logic                            we;     // write done, data unused
        logic [$clog2(`SDRAM_BANKS)-1:0] bank;
        logic [31:0]                     data;   // {beat 1, beat 0}
    } rd_rsp_t;

endpackage

/* hdl/sdram_dispatch.sv */
// AXI4-Lite front end: splits byte addresses, fills the bank slots and holds B/R responses
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_dispatch (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [`SDRAM_AXI_AW-1:0]                      awaddr,
    input  logic                                          awvalid,
    output logic                                          awready,
    input  logic [31:0]                                   wdata,
    input  logic [3:0]                                    wstrb,
    input  logic                                          wvalid,
    output logic                                          wready,
    output logic [1:0]                                    bresp,
    output logic                                          bvalid,
    input  logic                                          bready,
    input  logic [`SDRAM_AXI_AW-1:0]                      araddr,
    input  logic                                          arvalid,
    output logic                                          arready,
    output logic [31:0]                                   rdata,
    output logic [1:0]                                    rresp,
    output logic                                          rvalid,
    input  logic                                          rready,
    output sdram_host_pkg::bank_req_t [`SDRAM_BANKS-1:0] req,
    input  logic [`SDRAM_BANKS-1:0]                       accept,
    input  sdram_host_pkg::rd_rsp_t                       rsp
);

    localparam int BA_W   = $clog2(`SDRAM_BANKS);
    localparam int BA_LO  = `SDRAM_COL_W + 2;  // above column and byte offset
    localparam int ROW_LO = BA_LO + BA_W;

    logic [BA_W-1:0] aw_bank;
    logic [BA_W-1:0] ar_bank;
    logic            wr_busy;  // write in flight or waiting on bready
    logic            rd_busy;
    logic            wr_take;
    logic            rd_take;

    function automatic sdram_host_pkg::bank_req_t make_req(
        input logic [`SDRAM_AXI_AW-1:0] addr,
        input logic                     we,
        input logic [31:0]              data,
        input logic [3:0]               strb
    );
        sdram_host_pkg::bank_req_t r;
        r.valid = 1'b1;
        r.we    = we;
        r.row   = `SDRAM_ROW_W'(addr >> ROW_LO);
        r.col   = addr[2 +: `SDRAM_COL_W];
        r.wdata = data;
        r.wstrb = strb;
        return r;
    endfunction

    assign aw_bank = awaddr[BA_LO +: BA_W];
    assign ar_bank = araddr[BA_LO +: BA_W];

    // aw and w are taken together, only into a free slot
    assign wr_take = awvalid && wvalid && !wr_busy && !req[aw_bank].valid;
    assign rd_take = arvalid && !rd_busy && !req[ar_bank].valid &&
                     !(wr_take && aw_bank == ar_bank);  // write wins a shared slot

    assign awready = wr_take;
    assign wready  = wr_take;
    assign arready = rd_take;
    assign bresp   = 2'b00;
    assign rresp   = 2'b00;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req     <= '0;
            wr_busy <= 1'b0;
            rd_busy <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            for (int b = 0; b < `SDRAM_BANKS; b++) begin
                if (accept[b]) req[b].valid <= 1'b0;  // bank issued READ/WRITE
            end
            if (wr_take) begin
                req[aw_bank] <= make_req(awaddr, 1'b1, wdata, wstrb);
                wr_busy      <= 1'b1;
            end
            if (rd_take) begin
                req[ar_bank] <= make_req(araddr, 1'b0, '0, '0);
                rd_busy      <= 1'b1;
            end

            if (rsp.valid && rsp.we) bvalid <= 1'b1;
            if (rsp.valid && !rsp.we) rvalid <= 1'b1;
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                wr_busy <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp.valid && !rsp.we) rdata <= rsp.data;  // held while rvalid
    end

endmodule

/* hdl/sdram_bank.sv */
// SDRAM bank engine: tracks the open row and sequences precharge, activate and read/write
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_bank #(
    parameter int bank_id = 0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  sdram_host_pkg::bank_req_t req,
    output logic                      accept,
    input  logic                      grant,
    input  logic                      dq_busy,
    input  logic                      act_block,
    output sdram_cmd_pkg::bank_pins_t pins
);

    localparam int BA_W = $clog2(`SDRAM_BANKS);

    sdram_cmd_pkg::bank_state_e state;
    logic [`SDRAM_ROW_W-1:0]    open_row;
    logic                       prechd;    // no row open
    logic [3:0]                 wait_cnt;
    logic                       row_hit;
    logic                       go;        // bid granted this cycle

    assign row_hit = !prechd && open_row == req.row;
    assign go      = grant && pins.br;
    assign accept  = go && row_hit;        // only READ/WRITE consumes the request

    // pick the next command, bid only while it may go out
    always_comb begin
        pins     = '0;
        pins.cmd = sdram_cmd_pkg::NOP;
        pins.ba  = BA_W'(bank_id);
        if (state == sdram_cmd_pkg::IDLE && req.valid) begin
            if (prechd) begin
                pins.cmd = sdram_cmd_pkg::ACTIVE;
                pins.a   = req.row;
                pins.act = 1'b1;
                pins.br  = !act_block;
            end else if (!row_hit) begin
                pins.cmd = sdram_cmd_pkg::PRECHARGE;
                pins.a   = '0;             // A10 low, this bank only
                pins.br  = 1'b1;
            end else begin
                pins.cmd       = req.we ? sdram_cmd_pkg::WRITE : sdram_cmd_pkg::READ;
                pins.a         = `SDRAM_ROW_W'(req.col);  // no auto-precharge
                pins.launch_rd = !req.we;
                pins.launch_wr = req.we;
                pins.br        = !dq_busy;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= sdram_cmd_pkg::IDLE;
            prechd   <= 1'b1;              // device comes up with all banks closed
            wait_cnt <= '0;
        end else begin
            case (state)
                sdram_cmd_pkg::IDLE: begin
                    if (go) begin
                        if (prechd) begin
                            prechd   <= 1'b0;
                            state    <= sdram_cmd_pkg::ACT_WAIT;
                            wait_cnt <= 4'(`SDRAM_TRCD - 1);
                        end else if (!row_hit) begin
                            prechd   <= 1'b1;
                            state    <= sdram_cmd_pkg::PRE_WAIT;
                            wait_cnt <= 4'(`SDRAM_TRP - 1);
                        end else begin
                            state    <= sdram_cmd_pkg::XFER;
                            wait_cnt <= 4'd1;  // two beats, covers write recovery
                        end
                    end
                end
                sdram_cmd_pkg::PRE_WAIT,
                sdram_cmd_pkg::ACT_WAIT,
                sdram_cmd_pkg::XFER: begin
                    if (wait_cnt == 0) begin
                        state <= (state == sdram_cmd_pkg::XFER) ?
                                 sdram_cmd_pkg::DONE : sdram_cmd_pkg::IDLE;
                    end else begin
                        wait_cnt <= wait_cnt - 4'd1;
                    end
                end
                sdram_cmd_pkg::DONE: state <= sdram_cmd_pkg::IDLE;
                default: state <= sdram_cmd_pkg::IDLE;
            endcase
        end
    end

    // row address latched on ACTIVE
    always_ff @(posedge clk) begin
        if (go && prechd) open_row <= req.row;
    end

endmodule

/* hdl/sdram_bus_arbiter.sv */
// SDRAM bus arbiter: grants the command pins, tracks DQ and tRRD, moves data and completions
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_bus_arbiter (
    input  logic                                          clk,
    input  logic                                          rst,
    input  sdram_cmd_pkg::bank_pins_t [`SDRAM_BANKS-1:0] bids,
    input  sdram_host_pkg::bank_req_t [`SDRAM_BANKS-1:0] req,
    output logic [`SDRAM_BANKS-1:0]                       grant,
    output logic                                          dq_busy,
    output logic                                          act_block,
    output sdram_cmd_pkg::cmd_e                           cmd,
    output logic [$clog2(`SDRAM_BANKS)-1:0]               ba,
    output logic [`SDRAM_ROW_W-1:0]                       a,
    output logic [1:0]                                    dqm,
    output logic [15:0]                                   dq_out,
    output logic                                          dq_oe,
    input  logic [15:0]                                   dq_in,
    output sdram_host_pkg::rd_rsp_t                       rsp
);

    localparam int BA_W = $clog2(`SDRAM_BANKS);
    localparam int CL   = `SDRAM_CL;

    sdram_cmd_pkg::bank_pins_t win;
    logic [BA_W-1:0] sel;
    logic            found;
    logic            go_rd;
    logic            go_wr;
    logic            go_act;
    logic [2:0]      occ;         // bit k: DQ taken k cycles from now
    logic [3:0]      act_cnt;
    logic            wr_hi;       // second write beat on the bus
    logic [15:0]     wr_hi_data;
    logic [1:0]      wr_hi_mask;
    logic [BA_W-1:0] wr_bank;
    logic [CL:0]     rd_vld;      // read tag pipe, beats at CL-1 and CL
    logic [BA_W-1:0] rd_tag [CL+1];
    logic [15:0]     rd_lo;

    // lowest-numbered requester wins
    always_comb begin
        grant = '0;
        sel   = '0;
        found = 1'b0;
        for (int i = 0; i < `SDRAM_BANKS; i++) begin
            if (bids[i].br && !found) begin
                grant[i] = 1'b1;
                sel      = BA_W'(i);
                found    = 1'b1;
            end
        end
    end

    assign win    = bids[sel];
    assign go_rd  = found && win.launch_rd;
    assign go_wr  = found && win.launch_wr;
    assign go_act = found && win.act;

    assign cmd = found ? win.cmd : sdram_cmd_pkg::NOP;
    assign ba  = found ? win.ba : '0;
    assign a   = found ? win.a : '0;

    assign dq_busy   = |occ[1:0];
    assign act_block = act_cnt != 0;

    // write beat 0 straight from the slot, beat 1 from the latch
    always_comb begin
        dq_oe  = 1'b0;
        dq_out = '0;
        dqm    = '0;
        if (go_wr) begin
            dq_oe  = 1'b1;
            dq_out = req[sel].wdata[15:0];
            dqm    = ~req[sel].wstrb[1:0];
        end else if (wr_hi) begin
            dq_oe  = 1'b1;
            dq_out = wr_hi_data;
            dqm    = wr_hi_mask;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occ     <= '0;
            act_cnt <= '0;
            wr_hi   <= 1'b0;
            rd_vld  <= '0;
            rsp     <= '0;
        end else begin
            // write holds DQ one more cycle, read data lands at CL and CL+1
            occ <= (occ >> 1) | (go_wr ? 3'b001 : 3'b000) | (go_rd ? 3'b110 : 3'b000);
            if (go_act) act_cnt <= 4'(`SDRAM_TRRD - 1);
            else if (act_cnt != 0) act_cnt <= act_cnt - 4'd1;
            wr_hi  <= go_wr;
            rd_vld <= {rd_vld[CL-1:0], go_rd};
            if (wr_hi) begin
                rsp <= '{valid: 1'b1, we: 1'b1, bank: wr_bank, data: '0};
            end else if (rd_vld[CL]) begin
                rsp <= '{valid: 1'b1, we: 1'b0, bank: rd_tag[CL], data: {dq_in, rd_lo}};
            end else begin
                rsp.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go_wr) begin
            wr_hi_data <= req[sel].wdata[31:16];
            wr_hi_mask <= ~req[sel].wstrb[3:2];
            wr_bank    <= win.ba;
        end
        rd_tag[0] <= win.ba;
        for (int k = 1; k <= CL; k++) begin
            rd_tag[k] <= rd_tag[k-1];
        end
        if (rd_vld[CL-1]) rd_lo <= dq_in;  // first beat
    end

endmodule

/* hdl/sdram_ctrl.sv */
// SDRAM controller top: AXI4-Lite dispatcher, one engine per bank and the shared bus arbiter
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_ctrl (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [`SDRAM_AXI_AW-1:0]           awaddr,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [31:0]                        wdata,
    input  logic [3:0]                         wstrb,
    input  logic                               wvalid,
    output logic                               wready,
    output logic [1:0]                         bresp,
    output logic                               bvalid,
    input  logic                               bready,
    input  logic [`SDRAM_AXI_AW-1:0]           araddr,
    input  logic                               arvalid,
    output logic                               arready,
    output logic [31:0]                        rdata,
    output logic [1:0]                         rresp,
    output logic                               rvalid,
    input  logic                               rready,
    output sdram_cmd_pkg::cmd_e                cmd,
    output logic [$clog2(`SDRAM_BANKS)-1:0]    ba,
    output logic [`SDRAM_ROW_W-1:0]            a,
    output logic [1:0]                         dqm,
    output logic [15:0]                        dq_out,
    output logic                               dq_oe,
    input  logic [15:0]                        dq_in
);

    sdram_host_pkg::bank_req_t [`SDRAM_BANKS-1:0] req;
    sdram_cmd_pkg::bank_pins_t [`SDRAM_BANKS-1:0] bids;
    logic [`SDRAM_BANKS-1:0]                      accept;
    logic [`SDRAM_BANKS-1:0]                      grant;
    logic                                         dq_busy;
    logic                                         act_block;
    sdram_host_pkg::rd_rsp_t                      rsp;

    sdram_dispatch u_dispatch (.*);

    for (genvar i = 0; i < `SDRAM_BANKS; i++) begin : g_bank
        sdram_bank #(
            .bank_id(i)
        ) u_bank (
            .clk       (clk),
            .rst       (rst),
            .req       (req[i]),
            .accept    (accept[i]),
            .grant     (grant[i]),
            .dq_busy   (dq_busy),
            .act_block (act_block),
            .pins      (bids[i])
        );
    end

    sdram_bus_arbiter u_arbiter (.*);

endmodule

/* bench/sdram_model.sv */
// behavioural SDR SDRAM with four banks, CL 2, burst 2 and DQM masks, flags protocol violations
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_model (
    input  logic                            clk,
    input  logic                            rst,
    input  sdram_cmd_pkg::cmd_e             cmd,
    input  logic [$clog2(`SDRAM_BANKS)-1:0] ba,
    input  logic [`SDRAM_ROW_W-1:0]         a,
    input  logic [1:0]                      dqm,
    input  logic [15:0]                     dq_wr,     // controller side of DQ
    input  logic                            dq_oe,
    output logic [15:0]                     dq_rd,
    output logic                            bad_cmd,   // READ/WRITE to a closed bank, ACTIVE to an open one
    output logic                            bad_trrd,
    output logic                            bad_dq     // both sides drive DQ
);

    logic [15:0]             mem [int unsigned];   // key {bank, row, col, beat}
    logic [`SDRAM_BANKS-1:0] open_v;
    logic [`SDRAM_ROW_W-1:0] open_row [`SDRAM_BANKS];
    int unsigned             cyc;
    int unsigned             last_act;
    logic                    act_seen;
    logic                    rd_p0, rd_p1, rd_drv;
    int unsigned             rd_key0, rd_key1;
    logic                    wr_p;
    int unsigned             wr_key;
    int unsigned             cmd_key;
    logic                    is_xfer;

    function automatic logic [15:0] peek(input int unsigned k);
        return mem.exists(k) ? mem[k] : 16'h0000;
    endfunction

    function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] data,
                                          input logic [1:0] mask);
        logic [15:0] r;
        r = old;
        if (!mask[0]) r[7:0] = data[7:0];
        if (!mask[1]) r[15:8] = data[15:8];
        return r;
    endfunction

    assign cmd_key  = 32'({ba, open_row[ba], a[`SDRAM_COL_W-1:0], 1'b0});
    assign is_xfer  = cmd == sdram_cmd_pkg::READ || cmd == sdram_cmd_pkg::WRITE;
    assign bad_cmd  = (is_xfer && !open_v[ba]) || (cmd == sdram_cmd_pkg::ACTIVE && open_v[ba]);
    assign bad_trrd = cmd == sdram_cmd_pkg::ACTIVE && act_seen && (cyc - last_act) < `SDRAM_TRRD;
    assign bad_dq   = rd_drv && dq_oe;

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            open_v   <= '0;           // all banks closed, mode already set
            cyc      <= 0;
            last_act <= 0;
            act_seen <= 1'b0;
            rd_p0    <= 1'b0;
            rd_p1    <= 1'b0;
            rd_drv   <= 1'b0;
            wr_p     <= 1'b0;
            dq_rd    <= '0;
        end else begin
            cyc <= cyc + 1;
            if (wr_p) mem[wr_key] = merge(peek(wr_key), dq_wr, dqm);  // second write beat
            wr_p <= cmd == sdram_cmd_pkg::WRITE;
            wr_key <= cmd_key + 1;
            case (cmd)
                sdram_cmd_pkg::ACTIVE: begin
                    open_v[ba]   <= 1'b1;
                    open_row[ba] <= a;
                    last_act     <= cyc;
                    act_seen     <= 1'b1;
                end
                sdram_cmd_pkg::PRECHARGE: open_v[ba] <= 1'b0;
                sdram_cmd_pkg::WRITE: mem[cmd_key] = merge(peek(cmd_key), dq_wr, dqm);
                default: ;
            endcase
            // beat 0 on DQ one edge after READ, beat 1 the edge after
            rd_p0   <= cmd == sdram_cmd_pkg::READ;
            rd_key0 <= cmd_key;
            rd_p1   <= rd_p0;
            rd_key1 <= rd_key0 + 1;
            rd_drv  <= rd_p0 || rd_p1;
            if (rd_p0) dq_rd <= peek(rd_key0);
            else if (rd_p1) dq_rd <= peek(rd_key1);
        end
    end

endmodule

/* bench/tb_clock.sv */
// testbench clock and reset source, 20 ns period with reset held for 5 cycles
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* bench/sdram_ctrl_tb.sv */
// SDRAM controller testbench with AXI4-Lite traffic, a byte scoreboard and assertions
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_ctrl_tb;

    localparam int TMO    = 300;  // cycles allowed per wait
    localparam int BA_W   = $clog2(`SDRAM_BANKS);
    localparam int ROW_HI = `SDRAM_AXI_AW - `SDRAM_COL_W - 2 - BA_W;

    logic                     clk, rst;
    logic [`SDRAM_AXI_AW-1:0] awaddr, araddr;
    logic [31:0]              wdata, rdata;
    logic [3:0]               wstrb;
    logic [1:0]               bresp, rresp, dqm;
    logic                     awvalid, awready, wvalid, wready, bvalid, bready;
    logic                     arvalid, arready, rvalid, rready;
    sdram_cmd_pkg::cmd_e      cmd;
    logic [BA_W-1:0]          ba;
    logic [`SDRAM_ROW_W-1:0]  a;
    logic [15:0]              dq_out, dq_in;
    logic                     dq_oe;
    logic                     bad_cmd, bad_trrd, bad_dq;

    logic [7:0]               sb [int];    // byte-addressed reference memory
    logic [31:0]              exp_rdata;
    logic                     started;     // first request driven
    logic [`SDRAM_AXI_AW-1:0] pool [24];
    integer                   seed;

    tb_clock u_clock (.clk(clk), .rst(rst));

    sdram_ctrl dut (.*);

    sdram_model u_mem (
        .clk(clk), .rst(rst), .cmd(cmd), .ba(ba), .a(a), .dqm(dqm), .dq_wr(dq_out),
        .dq_oe(dq_oe), .dq_rd(dq_in), .bad_cmd(bad_cmd), .bad_trrd(bad_trrd), .bad_dq(bad_dq)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic flag_error(input string msg);
        abort_run($sformatf("[ERROR] %0t: %s", $time, msg));
    endtask

    a_idle: assert property (@(posedge clk) disable iff (rst) !started |->
        (cmd == sdram_cmd_pkg::NOP && !dq_oe && !bvalid && !rvalid))
        else flag_error("bus or response activity before the first request");
    a_resp: assert property (@(posedge clk) disable iff (rst)
        (!bvalid || bresp == 2'b00) && (!rvalid || rresp == 2'b00))
        else flag_error("response code is not OKAY");
    a_data: assert property (@(posedge clk) disable iff (rst) (rvalid && rready) |->
        rdata == exp_rdata) else flag_error($sformatf("rdata %h, expected %h", rdata, exp_rdata));
    a_rhold: assert property (@(posedge clk) disable iff (rst) $past(rvalid && !rready) |->
        (rvalid && rdata == $past(rdata))) else flag_error("read response changed while stalled");
    a_bhold: assert property (@(posedge clk) disable iff (rst) $past(bvalid && !bready) |->
        bvalid) else flag_error("write response dropped while stalled");
    a_row: assert property (@(posedge clk) disable iff (rst) !bad_cmd)
        else flag_error("command does not match the bank's open row state");
    a_trrd: assert property (@(posedge clk) disable iff (rst) !bad_trrd)
        else flag_error("two ACTIVE commands closer than tRRD");
    a_dq: assert property (@(posedge clk) disable iff (rst) !bad_dq)
        else flag_error("DQ driven by controller and memory at once");

    function automatic logic [`SDRAM_AXI_AW-1:0] make_addr(input int row, input int bank,
                                                            input int col);
        return {ROW_HI'(row), BA_W'(bank), `SDRAM_COL_W'(col), 2'b00};
    endfunction

    function automatic logic [31:0] expect_word(input logic [`SDRAM_AXI_AW-1:0] addr);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            if (sb.exists(int'(addr) + i)) w[8*i +: 8] = sb[int'(addr) + i];
        end
        return w;
    endfunction

    function automatic int random_stall();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    task automatic write_word(input logic [`SDRAM_AXI_AW-1:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input int stall);
        int n;
        n = 0;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        started = 1'b1;
        do begin
            @(posedge clk);
            n++;
            if (n > TMO) abort_run("write address and data were never accepted");
        end while (!awready && !wready);
        if (!(awready && wready)) begin
            flag_error($sformatf("awready %b and wready %b not together", awready, wready));
        end
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) sb[int'(addr) + i] = data[8*i +: 8];
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid) begin
            @(negedge clk);
            n++;
            if (n > TMO) abort_run("write response never arrived");
        end
        repeat (stall) @(negedge clk);  // bready held low
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic read_word(input logic [`SDRAM_AXI_AW-1:0] addr, input int stall);
        int n;
        n = 0;
        @(negedge clk);
        exp_rdata = expect_word(addr);
        araddr    = addr;
        arvalid   = 1'b1;
        started   = 1'b1;
        do begin
            @(posedge clk);
            n++;
            if (n > TMO) abort_run("read address was never accepted");
        end while (!arready);
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            @(negedge clk);
            n++;
            if (n > TMO) abort_run("read data never returned");
        end
        repeat (stall) @(negedge clk);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    initial begin
        int          n;
        int          wr_i;
        int          rd_i;
        int          wr_st;
        int          rd_st;
        logic [31:0] d;
        logic [3:0]  s;
        seed      = 32'hbbe;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        started   = 1'b0;
        exp_rdata = '0;
        n = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            n++;
            if (n > TMO) abort_run("reset was never released");
        end
        repeat (4) @(negedge clk);  // quiet bus after reset
        write_word(make_addr(5, 1, 17), 32'hcafe_1234, 4'hf, random_stall());
        read_word(make_addr(5, 1, 17), random_stall());
        // other row in the same bank
        write_word(make_addr(9, 1, 3), 32'h0bad_f00d, 4'hf, random_stall());
        read_word(make_addr(5, 1, 17), random_stall());
        read_word(make_addr(9, 1, 3), random_stall());
        write_word(make_addr(2, 3, 40), 32'h1122_3344, 4'hf, random_stall());
        write_word(make_addr(2, 3, 40), 32'haabb_ccdd, 4'b0101, random_stall());
        read_word(make_addr(2, 3, 40), random_stall());
        // few rows per bank so the mix has both hits and misses
        for (int i = 0; i < 24; i++) begin
            pool[i] = make_addr(int'($unsigned($random(seed)) % 3), i % `SDRAM_BANKS,
                                $random(seed));
        end
        for (int i = 0; i < 100; i++) begin
            wr_i  = int'($unsigned($random(seed)) % 24);
            rd_i  = int'($unsigned($random(seed)) % 24);
            d     = $random(seed);
            s     = 4'($random(seed));
            wr_st = random_stall();
            rd_st = random_stall();
            if (s == 4'h0) s = 4'hf;
            if (pool[wr_i] == pool[rd_i]) begin
                write_word(pool[wr_i], d, s, wr_st);
                read_word(pool[rd_i], rd_st);
            end else begin
                fork
                    write_word(pool[wr_i], d, s, wr_st);
                    read_word(pool[rd_i], rd_st);
                join
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hdl
hdl/sdram_cmd_pkg.sv
hdl/sdram_host_pkg.sv
hdl/sdram_dispatch.sv
hdl/sdram_bank.sv
hdl/sdram_bus_arbiter.sv
hdl/sdram_ctrl.sv
bench/sdram_model.sv
bench/tb_clock.sv
bench/sdram_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the SDRAM controller testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module sdram_ctrl_tb -o sdram_ctrl_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sdram_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0
